// ==== coeff_decode.f ====
hdl/coeff_decode_pkg.sv
hdl/bit_window_if.sv
hdl/coef_write_if.sv
hdl/bit_unpacker.sv
hdl/run_decoder.sv
hdl/block_store.sv
hdl/coeff_decode_top.sv
sim/coeff_check.sv
sim/tb_coeff_decode.sv

// ==== sim/tb_coeff_decode.sv ====
// Testbench for the coefficient decoder, builds a random coded stream
// and serves it word by word with random reply delays
`timescale 1ns/1ps
`default_nettype none

module tb_coeff_decode import coeff_decode_pkg::*; ();

	localparam int NUM_BLOCKS = 14;
	localparam int TIMEOUT    = 40000;  // Cycles for the whole stream

	logic              CLOCK_50_I = 1'b0;
	logic              resetn;
	logic              word_req;
	logic              word_valid;
	logic [WORD_W-1:0] word_data;
	logic              coef_valid;
	logic              block_first;
	logic [COEF_W-1:0] coef_out;
	int                error_count;
	int                blocks_done;
	integer            seed;
	bit                stream_bits [$];
	logic [WORD_W-1:0] words [$];
	int                word_idx;
	int                reply_wait;
	int                timeouts;
	int                cycles;

	always #10 CLOCK_50_I = ~CLOCK_50_I;

	coeff_decode_top coeff_decode_top_i (
		.CLOCK_50_I  (CLOCK_50_I),
		.resetn      (resetn),
		.word_req    (word_req),
		.word_valid  (word_valid),
		.word_data   (word_data),
		.coef_valid  (coef_valid),
		.block_first (block_first),
		.coef_out    (coef_out)
	);

	coeff_check check_i (
		.CLOCK_50_I  (CLOCK_50_I),
		.resetn      (resetn),
		.word_req    (word_req),
		.word_valid  (word_valid),
		.coef_valid  (coef_valid),
		.block_first (block_first),
		.coef_out    (coef_out),
		.error_count (error_count),
		.blocks_done (blocks_done)
	);

	function automatic int rand_below(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	task automatic push_bits(input logic [15:0] v, input int n);
		int i;
		for (i = n - 1; i >= 0; i--)
			stream_bits.push_back(v[i]);  // MSB first
	endtask

	// Mode 0 uses value codes only, mode 1 adds runs, mode 2 adds the end code
	task automatic build_block(input int mode);
		int          idx;
		int          cnt;
		int          run;
		int          k;
		code_t       c;
		logic [15:0] v;
		idx = 0;
		while (idx < BLOCK_N) begin
			if (mode == 0)
				c = code_t'(rand_below(2));
			else
				c = code_t'(rand_below(mode == 1 ? 5 : 6));
			run = 1;
			case (c)
				LONG_VAL: begin
					k = rand_below(512);
					push_bits(16'd0, 2);
					push_bits(k, 9);
					v = {{7{k[8]}}, k[8:0]};
				end
				SHORT_VAL: begin
					k = rand_below(16);
					push_bits(16'd1, 2);
					push_bits(k, 4);
					v = {{12{k[3]}}, k[3:0]};
				end
				RUN_NEG, RUN_POS: begin
					cnt = rand_below(4);
					push_bits((c == RUN_NEG) ? 16'b100 : 16'b101, 3);
					push_bits(cnt, 2);
					run = (cnt == 0) ? 4 : cnt;
					v   = (c == RUN_NEG) ? 16'hffff : 16'h0001;
				end
				RUN_ZERO: begin
					cnt = rand_below(8);
					push_bits(16'b110, 3);
					push_bits(cnt, 3);
					run = (cnt == 0) ? 8 : cnt;
					v   = 16'h0000;
				end
				default: begin
					push_bits(16'b111, 3);
					run = BLOCK_N - idx;
					v   = 16'h0000;
				end
			endcase
			while (run > 0 && idx < BLOCK_N) begin  // Cut at the block end
				check_i.add_value(v);
				idx++;
				run--;
			end
		end
	endtask

	task automatic build_stream();
		int          b;
		int          i;
		int          k;
		logic [15:0] w;
		for (b = 0; b < NUM_BLOCKS; b++)
			build_block(b < 3 ? 0 : (b < 6 ? 1 : 2));
		while (stream_bits.size() % WORD_W != 0)
			stream_bits.push_back(1'b0);  // Too short to finish another block
		for (i = 0; i < stream_bits.size(); i += WORD_W) begin
			w = '0;
			for (k = 0; k < WORD_W; k++)
				w = {w[14:0], stream_bits[i+k]};
			words.push_back(w);
		end
	endtask

	// Word responder, one reply per request after 1 to 6 cycles
	always @(posedge CLOCK_50_I) begin
		#2;
		word_valid = 1'b0;
		if (reply_wait > 0) begin
			reply_wait = reply_wait - 1;
			if (reply_wait == 0 && word_idx < words.size()) begin
				word_valid = 1'b1;
				word_data  = words[word_idx];
				word_idx++;
			end
		end else if (resetn && word_req) begin
			reply_wait = 1 + rand_below(6);
		end
	end

	initial begin
		seed       = 27;
		resetn     = 1'b0;
		word_valid = 1'b0;
		word_data  = '0;
		word_idx   = 0;
		reply_wait = 0;
		timeouts   = 0;
		build_stream();
		repeat (16) @(posedge CLOCK_50_I);
		#2 resetn = 1'b1;

		cycles = 0;
		while (blocks_done < NUM_BLOCKS && cycles < TIMEOUT) begin
			@(posedge CLOCK_50_I);
			cycles++;
		end
		if (blocks_done < NUM_BLOCKS) begin
			$display("Timed out with only %0d of %0d blocks received", blocks_done, NUM_BLOCKS);
			timeouts++;
		end else begin
			repeat (200) @(posedge CLOCK_50_I);  // Catch any extra output
		end

		$display("Blocks: %0d, compare errors: %0d, timeouts: %0d",
			blocks_done, error_count, timeouts);
		if (error_count == 0 && timeouts == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/coeff_check.sv ====
// Output checker for the coefficient decoder, rebuilds each block from
// the zigzag-order values the stimulus recorded and compares in raster order
`timescale 1ns/1ps
`default_nettype none

module coeff_check import coeff_decode_pkg::*; (
	input  logic              CLOCK_50_I,
	input  logic              resetn,
	input  logic              word_req,
	input  logic              word_valid,
	input  logic              coef_valid,
	input  logic              block_first,
	input  logic [COEF_W-1:0] coef_out,
	output int                error_count,
	output int                blocks_done
);

	logic [COEF_W-1:0] exp_vals [$];  // Zigzag order, block after block
	int                raster_to_zz [64];
	int                blk;
	int                idx;             // Raster position within the block
	logic              req_open;        // Request seen, word not yet returned

	task automatic add_value(input logic [COEF_W-1:0] v);
		exp_vals.push_back(v);
	endtask

	function automatic int diag_shift(input int d);
		if (d == 1)
			return 2;
		else if (d <= 3)
			return 3;  // Also the DC term
		else if (d <= 5)
			return 4;
		else if (d <= 7)
			return 5;
		return 6;
	endfunction

	function automatic logic [COEF_W-1:0] ref_coef(input int b, input int p);
		logic [COEF_W-1:0] v;
		v = exp_vals[b*BLOCK_N + raster_to_zz[p]];
		return v << diag_shift(p / 8 + p % 8);
	endfunction

	// Zigzag walk, one anti-diagonal at a time
	initial begin : walk
		int d;
		int k;
		int r;
		int n;
		n = 0;
		for (d = 0; d < 15; d++) begin
			for (k = 0; k < 8; k++) begin
				r = (d % 2 == 0) ? d - k : k;  // Even diagonals climb upward
				if (r >= 0 && r < 8 && d - r >= 0 && d - r < 8) begin
					raster_to_zz[r*8 + d - r] = n;
					n++;
				end
			end
		end
	end

	always @(posedge CLOCK_50_I) begin : compare
		int                errs;
		logic [COEF_W-1:0] expected;
		errs = 0;
		if (!resetn) begin
			blk = 0;
			idx = 0;
			req_open = 1'b0;
			error_count <= 0;
			blocks_done <= 0;
		end else begin
			// Only one word may be outstanding at a time
			if (word_req && req_open) begin
				$display("word_req pulsed again before the previous word arrived");
				errs++;
			end
			if (word_valid)
				req_open = 1'b0;
			if (word_req)
				req_open = 1'b1;

			if (coef_valid) begin
				if (blk >= exp_vals.size() / BLOCK_N) begin
					$display("More coefficients came out than the stream holds");
					errs++;
				end else begin
					expected = ref_coef(blk, idx);
					if (coef_out !== expected) begin
						$display("Error: coef_out block %0d raster %0d: got %h, expected %h",
							blk, idx, coef_out, expected);
						errs++;
					end
				end
				if (block_first !== (idx == 0)) begin
					$display("Error: block_first block %0d raster %0d: got %h, expected %h",
						blk, idx, block_first, idx == 0);
					errs++;
				end
				idx++;
				if (idx == BLOCK_N) begin
					idx = 0;
					blk++;
					blocks_done <= blk;
				end
			end else begin
				if (block_first) begin
					$display("block_first went high while coef_valid was low");
					errs++;
				end
				if (idx != 0) begin
					$display("coef_valid dropped after %0d coefficients of block %0d", idx, blk);
					errs++;
					idx = 0;  // Resync on the next block
					blk++;
					blocks_done <= blk;
				end
			end
			error_count <= error_count + errs;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/coeff_decode_top.sv ====
// Block coefficient decoder top, word fetch in, raster coefficients out
`timescale 1ns/1ps
`default_nettype none

module coeff_decode_top import coeff_decode_pkg::*; (
	input  logic              CLOCK_50_I,
	input  logic              resetn,
	output logic              word_req,
	input  logic              word_valid,
	input  logic [WORD_W-1:0] word_data,
	output logic              coef_valid,
	output logic              block_first,
	output logic [COEF_W-1:0] coef_out
);

	bit_window_if win_if ();
	coef_write_if wr_if ();

	bit_unpacker bit_unpacker_i (
		.CLOCK_50_I (CLOCK_50_I),
		.resetn     (resetn),
		.word_req   (word_req),
		.word_valid (word_valid),
		.word_data  (word_data),
		.win        (win_if.unpacker)
	);

	run_decoder run_decoder_i (
		.CLOCK_50_I (CLOCK_50_I),
		.resetn     (resetn),
		.win        (win_if.decoder),
		.wr         (wr_if.decoder)
	);

	block_store block_store_i (
		.CLOCK_50_I  (CLOCK_50_I),
		.resetn      (resetn),
		.wr          (wr_if.store),
		.coef_valid  (coef_valid),
		.block_first (block_first),
		.coef_out    (coef_out)
	);

endmodule

`default_nettype wire

// ==== hdl/block_store.sv ====
// Block store, two 64-entry banks written by the decoder
// and streamed out in raster order through a registered read
`timescale 1ns/1ps
`default_nettype none

module block_store import coeff_decode_pkg::*; (
	input  logic              CLOCK_50_I,
	input  logic              resetn,
	coef_write_if.store       wr,
	output logic              coef_valid,
	output logic              block_first,
	output logic [COEF_W-1:0] coef_out
);

	logic [COEF_W-1:0] mem [2*BLOCK_N];  // Bank select is the address MSB
	logic [1:0]        full;             // Bank holds a block awaiting readout
	logic [1:0]        ready_bank;
	logic              wr_bank;
	logic              rd_bank;
	rd_state_t         rd_state;
	logic [POS_W-1:0]  rd_cnt;
	logic              rd_last;

	assign wr.bank_free = !full[wr_bank];

	// Includes a block completing this very cycle
	assign ready_bank = full | ({1'b0, wr.block_done} << wr_bank);
	assign rd_last    = (rd_cnt == POS_W'(BLOCK_N - 1));

	always_ff @(posedge CLOCK_50_I) begin
		if (wr.we)
			mem[{wr_bank, wr.pos}] <= wr.coef;
		if (rd_state == READ)
			coef_out <= mem[{rd_bank, rd_cnt}];
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			full        <= '0;
			wr_bank     <= 1'b0;
			rd_bank     <= 1'b0;
			rd_state    <= IDLE;
			rd_cnt      <= '0;
			coef_valid  <= 1'b0;
			block_first <= 1'b0;
		end else begin
			coef_valid  <= (rd_state == READ);  // Follows the read address by one
			block_first <= (rd_state == READ) && (rd_cnt == '0);

			if (wr.block_done) begin
				full[wr_bank] <= 1'b1;
				wr_bank       <= !wr_bank;
			end

			case (rd_state)
				IDLE: begin
					if (ready_bank[rd_bank]) begin
						rd_state <= READ;
						rd_cnt   <= '0;
					end
				end
				READ: begin
					rd_cnt <= rd_cnt + 1'b1;
					if (rd_last) begin
						full[rd_bank] <= 1'b0;  // Never the bank being completed
						rd_bank       <= !rd_bank;
						if (!ready_bank[!rd_bank])
							rd_state <= IDLE;   // Otherwise go straight on
					end
				end
				default: rd_state <= IDLE;
			endcase
		end
	end

	// Decoder must hold off until the bank has been read out
	a_no_write_full: assert property (
		@(posedge CLOCK_50_I) disable iff (!resetn)
		wr.we |-> !full[wr_bank]
	);

endmodule

`default_nettype wire

// ==== hdl/run_decoder.sv ====
// Run decoder, turns variable-length codes into zigzag-ordered coefficients
// scaled by position and written into the block store
`timescale 1ns/1ps
`default_nettype none

module run_decoder import coeff_decode_pkg::*; (
	input  logic          CLOCK_50_I,
	input  logic          resetn,
	bit_window_if.decoder win,
	coef_write_if.decoder wr
);

	dec_state_t         state;
	code_t              code;
	logic [AVAIL_W-1:0] code_len;
	logic [COEF_W-1:0]  value;
	logic [POS_W:0]     run_len;    // Coefficients this code yields
	logic [POS_W-1:0]   zz_idx;
	logic [POS_W:0]     run_left;
	logic [COEF_W-1:0]  run_val;
	logic [COEF_W-1:0]  cur_val;
	logic [POS_W-1:0]   pos;
	logic               fits;
	logic               last;

	always_comb begin
		case (win.window[WIN_W-1 -: 3])
			3'b000, 3'b001: code = LONG_VAL;
			3'b010, 3'b011: code = SHORT_VAL;
			3'b100:         code = RUN_NEG;
			3'b101:         code = RUN_POS;
			3'b110:         code = RUN_ZERO;
			default:        code = END_BLOCK;
		endcase
	end

	// Field positions assume a 16-bit window
	always_comb begin
		value   = '0;
		run_len = 7'd1;
		case (code)
			LONG_VAL: begin
				code_len = 6'd11;
				value    = {{(COEF_W-9){win.window[13]}}, win.window[13:5]};
			end
			SHORT_VAL: begin
				code_len = 6'd6;
				value    = {{(COEF_W-4){win.window[13]}}, win.window[13:10]};
			end
			RUN_NEG, RUN_POS: begin
				code_len = 6'd5;
				value    = (code == RUN_NEG) ? '1 : COEF_W'(1);
				run_len  = (win.window[12:11] == 2'd0) ? 7'd4 : {5'd0, win.window[12:11]};
			end
			RUN_ZERO: begin
				code_len = 6'd6;
				run_len  = (win.window[12:10] == 3'd0) ? 7'd8 : {4'd0, win.window[12:10]};
			end
			default: begin
				code_len = 6'd3;
				run_len  = 7'(BLOCK_N) - {1'b0, zz_idx};  // Rest of the block
			end
		endcase
	end

	assign fits = (state == PARSE) && (code_len <= win.avail);
	assign last = (zz_idx == POS_W'(BLOCK_N - 1));

	assign win.consume     = fits;
	assign win.consume_len = code_len;

	assign cur_val = (state == RUN) ? run_val : value;
	assign pos     = zigzag_table[zz_idx];

	assign wr.we         = fits || (state == RUN);
	assign wr.pos        = pos;
	assign wr.coef       = cur_val << qshift_table[pos];
	assign wr.block_done = wr.we && last;

	// Runs past index 63 are simply dropped at the block end
	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			state    <= PARSE;
			zz_idx   <= '0;
			run_left <= '0;
		end else begin
			if (wr.we)
				zz_idx <= zz_idx + 1'b1;  // Wraps to 0 after the last write
			case (state)
				PARSE: begin
					if (fits) begin
						run_left <= run_len - 1'b1;
						if (last)
							state <= WAIT_BANK;
						else if (run_len > 7'd1)
							state <= RUN;
					end
				end
				RUN: begin
					run_left <= run_left - 1'b1;
					if (last)
						state <= WAIT_BANK;
					else if (run_left == 7'd1)
						state <= PARSE;
				end
				WAIT_BANK: begin
					if (wr.bank_free)
						state <= PARSE;
				end
				default: state <= PARSE;
			endcase
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (fits)
			run_val <= value;
	end

	// A run in progress always has coefficients left to write
	a_run_not_empty: assert property (
		@(posedge CLOCK_50_I) disable iff (!resetn)
		(state == RUN) |-> (run_left != '0)
	);

endmodule

`default_nettype wire

// ==== hdl/bit_unpacker.sv ====
// Bit unpacker, fetches 16-bit words into a left-aligned bit buffer
// and drops the bits the decoder consumes
`timescale 1ns/1ps
`default_nettype none

module bit_unpacker import coeff_decode_pkg::*; (
	input  logic              CLOCK_50_I,
	input  logic              resetn,
	output logic              word_req,
	input  logic              word_valid,
	input  logic [WORD_W-1:0] word_data,
	bit_window_if.unpacker    win
);

	logic [BUF_W-1:0]   bit_buf;
	logic [AVAIL_W-1:0] avail_cnt;
	logic               pending;     // Request out, word not yet back
	logic [AVAIL_W-1:0] drop;
	logic [AVAIL_W-1:0] avail_left;
	logic [BUF_W-1:0]   incoming;

	assign drop       = win.consume ? win.consume_len : '0;
	assign avail_left = avail_cnt - drop;

	// New word lands right below the bits that survive this cycle
	assign incoming = {word_data, {(BUF_W-WORD_W){1'b0}}} >> avail_left;

	assign win.window = bit_buf[BUF_W-1 -: WIN_W];
	assign win.avail  = avail_cnt;

	// Bits below avail_cnt are kept at zero so the OR merge works
	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			bit_buf   <= '0;
			avail_cnt <= '0;
			pending   <= 1'b0;
			word_req  <= 1'b0;
		end else begin
			word_req <= 1'b0;
			if (word_valid) begin
				bit_buf   <= (bit_buf << drop) | incoming;
				avail_cnt <= avail_left + AVAIL_W'(WORD_W);
			end else begin
				bit_buf   <= bit_buf << drop;
				avail_cnt <= avail_left;
			end

			if (word_valid) begin
				pending <= 1'b0;
			end else if (!pending && avail_cnt <= AVAIL_W'(BUF_W - WORD_W)) begin
				// Room for a full word, and avail only shrinks until it arrives
				word_req <= 1'b1;
				pending  <= 1'b1;
			end
		end
	end

	// Every word must answer a request we issued
	a_word_requested: assert property (
		@(posedge CLOCK_50_I) disable iff (!resetn)
		word_valid |-> pending
	);

endmodule

`default_nettype wire

// ==== hdl/coef_write_if.sv ====
// Coefficient writes from the decoder into the block store
`timescale 1ns/1ps
`default_nettype none

interface coef_write_if import coeff_decode_pkg::*; ();

	logic              we;
	logic [POS_W-1:0]  pos;         // Raster position
	logic [COEF_W-1:0] coef;
	logic              block_done;  // With the last write of a block
	logic              bank_free;

	modport decoder (output we, output pos, output coef, output block_done, input bank_free);

	modport store (input we, input pos, input coef, input block_done, output bank_free);

endinterface

`default_nettype wire

// ==== hdl/bit_window_if.sv ====
// Bit window from the unpacker to the decoder, with the consume handshake
`timescale 1ns/1ps
`default_nettype none

interface bit_window_if import coeff_decode_pkg::*; ();

	logic [WIN_W-1:0]   window;       // Oldest bit at the MSB
	logic [AVAIL_W-1:0] avail;        // Valid bits in the buffer
	logic               consume;
	logic [AVAIL_W-1:0] consume_len;

	modport unpacker (output window, output avail, input consume, input consume_len);

	modport decoder (input window, input avail, output consume, output consume_len);

endinterface

`default_nettype wire

// ==== hdl/coeff_decode_pkg.sv ====
// Shared widths, code and state types for the block coefficient decoder
// Also holds the zigzag walk and the per-position shift table
`default_nettype none

package coeff_decode_pkg;

	localparam int WORD_W  = 16;  // Bitstream word
	localparam int BUF_W   = 32;  // Unpacker bit buffer
	localparam int WIN_W   = 16;  // Window shown to the decoder
	localparam int AVAIL_W = 6;   // Holds 0 to 32
	localparam int COEF_W  = 16;
	localparam int BLOCK_N = 64;
	localparam int POS_W   = 6;

	typedef enum logic [2:0] {
		SHORT_VAL,   // 01 + 4-bit value
		LONG_VAL,    // 00 + 9-bit value
		RUN_NEG,     // 100 + count
		RUN_POS,     // 101 + count
		RUN_ZERO,    // 110 + count
		END_BLOCK    // 111
	} code_t;

	typedef enum logic [1:0] {PARSE, RUN, WAIT_BANK} dec_state_t;

	typedef enum logic {IDLE, READ} rd_state_t;

	// Raster position for each zigzag index
	localparam logic [POS_W-1:0] zigzag_table [BLOCK_N] = '{
		0,  1,  8, 16,  9,  2,  3, 10, 17, 24, 32, 25, 18, 11,  4,  5,
		12, 19, 26, 33, 40, 48, 41, 34, 27, 20, 13,  6,  7, 14, 21, 28,
		35, 42, 49, 56, 57, 50, 43, 36, 29, 22, 15, 23, 30, 37, 44, 51,
		58, 59, 52, 45, 38, 31, 39, 46, 53, 60, 61, 54, 47, 55, 62, 63
	};

	// Left shift per raster position, one row of the block per line
	localparam logic [2:0] qshift_table [BLOCK_N] = '{
		3, 2, 3, 3, 4, 4, 5, 5,
		2, 3, 3, 4, 4, 5, 5, 6,
		3, 3, 4, 4, 5, 5, 6, 6,
		3, 4, 4, 5, 5, 6, 6, 6,
		4, 4, 5, 5, 6, 6, 6, 6,
		4, 5, 5, 6, 6, 6, 6, 6,
		5, 5, 6, 6, 6, 6, 6, 6,
		5, 6, 6, 6, 6, 6, 6, 6
	};

endpackage

`default_nettype wire
